/* crate_bridge_pkg.sv */
package crate_bridge_pkg;

    // Link fan-out
    localparam int LINK_COUNT = 4;
    localparam int LINK_SEL_W = 2;

    // Crate register space, top LINK_SEL_W address bits pick the link
    localparam int ADDR_W      = 27;
    localparam int LINK_ADDR_W = 25;
    localparam int DATA_W      = 32;
    localparam int TAG_W       = 4;

    // Remote response wait in ps_clk cycles, counted from the command
    localparam int TIMEOUT_CYCLES = 64;
    localparam int TIMER_W        = $clog2(TIMEOUT_CYCLES);

    // Two bits of bridge type per link in the configuration word
    localparam int BRIDGE_TYPE_W = 2;
    localparam int BRIDGE_CFG_W  = LINK_COUNT * BRIDGE_TYPE_W;

    // Types 2 and 3 are not implemented, any access through them is invalid
    typedef enum logic [BRIDGE_TYPE_W-1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

    // Completion status
    typedef enum logic [1:0] {
        STATUS_OK        = 2'd0,
        STATUS_NO_BRIDGE = 2'd1,
        STATUS_INVALID   = 2'd2,
        STATUS_TIMEOUT   = 2'd3
    } resp_status_e;

    // Link channel states
    typedef enum logic [1:0] {
        CH_IDLE = 2'd0,
        CH_WAIT = 2'd1,
        CH_DONE = 2'd2
    } chan_state_e;

endpackage

/* crate_access_dispatch.sv */
`timescale 1ns/1ns

module crate_access_dispatch import crate_bridge_pkg::*; (
    input  logic                    ps_clk,
    input  logic                    rst_i,
    input  logic                    req_valid_i,
    input  logic                    req_write_i,
    input  logic [ADDR_W-1:0]       req_addr_i,
    input  logic [DATA_W-1:0]       req_wdata_i,
    input  logic [TAG_W-1:0]        req_tag_i,
    input  logic                    cfg_valid_i,
    input  logic [BRIDGE_CFG_W-1:0] cfg_type_i,
    output logic [LINK_COUNT-1:0]   chan_req_o,
    output logic                    chan_write_o,
    output logic [LINK_ADDR_W-1:0]  chan_addr_o,
    output logic [DATA_W-1:0]       chan_wdata_o,
    output logic [TAG_W-1:0]        chan_tag_o,
    output bridge_type_e            chan_type_o [LINK_COUNT]
);

    // Bridge type per link
    bridge_type_e          type_q [LINK_COUNT];
    logic [LINK_SEL_W-1:0] link_sel;

    // Link index from the top of the crate address
    assign link_sel = req_addr_i[ADDR_W-1 -: LINK_SEL_W];

    ////////////////////////////////////////////////////////////////////////////
    // Configuration and request strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            for (int n = 0; n < LINK_COUNT; n++) begin
                type_q[n] <= BRIDGE_NONE;
            end
            chan_req_o <= '0;
        end else begin
            // A config write replaces every link's type at once
            if (cfg_valid_i) begin
                for (int n = 0; n < LINK_COUNT; n++) begin
                    type_q[n] <= bridge_type_e'(cfg_type_i[n*BRIDGE_TYPE_W +: BRIDGE_TYPE_W]);
                end
            end
            chan_req_o <= '0;
            if (req_valid_i) begin
                chan_req_o[link_sel] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request payload, shared by all channels
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (req_valid_i) begin
            chan_write_o <= req_write_i;
            chan_addr_o  <= req_addr_i[LINK_ADDR_W-1:0];
            chan_wdata_o <= req_wdata_i;
            chan_tag_o   <= req_tag_i;
            // Type is frozen for the channel at request time
            chan_type_o[link_sel] <= type_q[link_sel];
        end
    end

endmodule

/* crate_link_channel.sv */
`timescale 1ns/1ns

module crate_link_channel import crate_bridge_pkg::*; (
    input  logic                   ps_clk,
    input  logic                   rst_i,
    input  logic                   req_i,
    input  logic                   write_i,
    input  logic [LINK_ADDR_W-1:0] addr_i,
    input  logic [DATA_W-1:0]      wdata_i,
    input  logic [TAG_W-1:0]       tag_i,
    input  bridge_type_e           type_i,
    input  logic                   link_up_i,
    output logic                   cmd_valid_o,
    output logic                   cmd_write_o,
    output logic [LINK_ADDR_W-1:0] cmd_addr_o,
    output logic [DATA_W-1:0]      cmd_wdata_o,
    input  logic                   resp_valid_i,
    input  logic [DATA_W-1:0]      resp_data_i,
    output logic                   done_o,
    output resp_status_e           status_o,
    output logic [DATA_W-1:0]      rdata_o,
    output logic [TAG_W-1:0]       tag_o,
    input  logic                   take_i
);

    chan_state_e        state_q;
    logic [TIMER_W-1:0] timer_q;
    logic               start;
    logic               forward;
    logic               timer_end;

    assign start = (state_q == CH_IDLE) && req_i;
    // Only an Aurora bridge on a live link goes out on the wire
    assign forward   = (type_i == BRIDGE_AURORA) && link_up_i;
    assign timer_end = (timer_q == TIMER_W'(TIMEOUT_CYCLES - 1));
    assign done_o    = (state_q == CH_DONE);

    ////////////////////////////////////////////////////////////////////////////
    // Access FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            state_q     <= CH_IDLE;
            cmd_valid_o <= 1'b0;
            timer_q     <= '0;
        end else begin
            cmd_valid_o <= 1'b0;
            case (state_q)
                CH_IDLE: begin
                    timer_q <= '0;
                    if (req_i) begin
                        if (forward) begin
                            cmd_valid_o <= 1'b1;
                            state_q     <= CH_WAIT;
                        end else begin
                            state_q <= CH_DONE;
                        end
                    end
                end
                CH_WAIT: begin
                    // Timer starts on the cycle the command is on the link
                    timer_q <= timer_q + 1'b1;
                    if (resp_valid_i || timer_end) begin
                        state_q <= CH_DONE;
                    end
                end
                CH_DONE: begin
                    if (take_i) begin
                        state_q <= CH_IDLE;
                    end
                end
                default: state_q <= CH_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command and completion payload
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (start) begin
            cmd_write_o <= write_i;
            cmd_addr_o  <= addr_i;
            cmd_wdata_o <= wdata_i;
            tag_o       <= tag_i;
            rdata_o     <= '0;
            case (type_i)
                BRIDGE_NONE:   status_o <= STATUS_NO_BRIDGE;
                BRIDGE_AURORA: status_o <= link_up_i ? STATUS_OK : STATUS_INVALID;
                default:       status_o <= STATUS_INVALID;
            endcase
        end else if (state_q == CH_WAIT) begin
            if (resp_valid_i) begin
                status_o <= STATUS_OK;
                // Write acks carry no data
                rdata_o  <= cmd_write_o ? '0 : resp_data_i;
            end else if (timer_end) begin
                status_o <= STATUS_TIMEOUT;
            end
        end
    end

    // Dispatcher never sends a new access before the last one was taken
    a_req_only_idle: assert property (@(posedge ps_clk) disable iff (rst_i)
        req_i |-> state_q == CH_IDLE)
        else $error("request to link channel while busy");

    // Completion must hold until the merger takes it
    a_done_hold: assert property (@(posedge ps_clk) disable iff (rst_i)
        done_o && !take_i |=> done_o && $stable(status_o) && $stable(rdata_o)
            && $stable(tag_o))
        else $error("completion changed before take");

    a_cmd_single: assert property (@(posedge ps_clk) disable iff (rst_i)
        cmd_valid_o |=> !cmd_valid_o)
        else $error("command strobe longer than one cycle");

endmodule

/* crate_response_merge.sv */
`timescale 1ns/1ns

module crate_response_merge import crate_bridge_pkg::*; (
    input  logic                  ps_clk,
    input  logic                  rst_i,
    input  logic                  clear_flags_i,
    input  logic [LINK_COUNT-1:0] done_i,
    input  resp_status_e          status_i [LINK_COUNT],
    input  logic [DATA_W-1:0]     rdata_i [LINK_COUNT],
    input  logic [TAG_W-1:0]      tag_i [LINK_COUNT],
    output logic [LINK_COUNT-1:0] take_o,
    output logic                  resp_valid_o,
    output resp_status_e          resp_status_o,
    output logic [DATA_W-1:0]     resp_rdata_o,
    output logic [TAG_W-1:0]      resp_tag_o,
    output logic [LINK_SEL_W-1:0] resp_link_o,
    output logic [LINK_COUNT-1:0] timeout_flag_o,
    output logic [LINK_COUNT-1:0] invalid_flag_o
);

    // Round-robin start point, one past the last channel served
    logic [LINK_SEL_W-1:0] rr_q;
    logic                  pick_valid;
    logic [LINK_SEL_W-1:0] pick_idx;
    resp_status_e          pick_status;
    logic [LINK_COUNT-1:0] set_timeout;
    logic [LINK_COUNT-1:0] set_invalid;

    ////////////////////////////////////////////////////////////////////////////
    // Channel pick
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [LINK_SEL_W-1:0] idx;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int i = 0; i < LINK_COUNT; i++) begin
            // Index wraps since LINK_COUNT is a power of two
            idx = rr_q + LINK_SEL_W'(i);
            if (!pick_valid && done_i[idx]) begin
                pick_valid = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    assign take_o      = pick_valid ? (LINK_COUNT'(1) << pick_idx) : '0;
    assign pick_status = status_i[pick_idx];
    assign set_timeout = (pick_valid && pick_status == STATUS_TIMEOUT) ? take_o : '0;
    assign set_invalid = (pick_valid && pick_status == STATUS_INVALID) ? take_o : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Output strobe and sticky flags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            rr_q           <= '0;
            resp_valid_o   <= 1'b0;
            timeout_flag_o <= '0;
            invalid_flag_o <= '0;
        end else begin
            resp_valid_o <= pick_valid;
            if (pick_valid) begin
                rr_q <= pick_idx + 1'b1;
            end
            // New flag wins over a clear in the same cycle
            timeout_flag_o <= (clear_flags_i ? '0 : timeout_flag_o) | set_timeout;
            invalid_flag_o <= (clear_flags_i ? '0 : invalid_flag_o) | set_invalid;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (pick_valid) begin
            resp_status_o <= pick_status;
            resp_rdata_o  <= rdata_i[pick_idx];
            resp_tag_o    <= tag_i[pick_idx];
            resp_link_o   <= pick_idx;
        end
    end

    a_take_onehot: assert property (@(posedge ps_clk) disable iff (rst_i)
        $onehot0(take_o))
        else $error("more than one channel taken");

endmodule

/* crate_bridge_top.sv */
`timescale 1ns/1ns

module crate_bridge_top import crate_bridge_pkg::*; (
    input  logic                                  ps_clk,
    input  logic                                  rst_i,
    input  logic                                  req_valid_i,
    input  logic                                  req_write_i,
    input  logic [ADDR_W-1:0]                     req_addr_i,
    input  logic [DATA_W-1:0]                     req_wdata_i,
    input  logic [TAG_W-1:0]                      req_tag_i,
    input  logic                                  cfg_valid_i,
    input  logic [BRIDGE_CFG_W-1:0]               cfg_type_i,
    input  logic                                  clear_flags_i,
    input  logic [LINK_COUNT-1:0]                 link_up_i,
    output logic [LINK_COUNT-1:0]                 link_cmd_valid_o,
    output logic [LINK_COUNT-1:0]                 link_cmd_write_o,
    output logic [LINK_COUNT-1:0][LINK_ADDR_W-1:0] link_cmd_addr_o,
    output logic [LINK_COUNT-1:0][DATA_W-1:0]     link_cmd_wdata_o,
    input  logic [LINK_COUNT-1:0]                 link_resp_valid_i,
    input  logic [LINK_COUNT-1:0][DATA_W-1:0]     link_resp_data_i,
    output logic                                  resp_valid_o,
    output resp_status_e                          resp_status_o,
    output logic [DATA_W-1:0]                     resp_rdata_o,
    output logic [TAG_W-1:0]                      resp_tag_o,
    output logic [LINK_SEL_W-1:0]                 resp_link_o,
    output logic [LINK_COUNT-1:0]                 timeout_flag_o,
    output logic [LINK_COUNT-1:0]                 invalid_flag_o
);

    // Dispatcher to channels
    logic [LINK_COUNT-1:0]  chan_req;
    logic                   chan_write;
    logic [LINK_ADDR_W-1:0] chan_addr;
    logic [DATA_W-1:0]      chan_wdata;
    logic [TAG_W-1:0]       chan_tag;
    bridge_type_e           chan_type [LINK_COUNT];

    // Channels to merger
    logic [LINK_COUNT-1:0]  chan_done;
    logic [LINK_COUNT-1:0]  chan_take;
    resp_status_e           chan_status [LINK_COUNT];
    logic [DATA_W-1:0]      chan_rdata [LINK_COUNT];
    logic [TAG_W-1:0]       chan_tag_out [LINK_COUNT];

    crate_access_dispatch u_dispatch (
        .ps_clk       (ps_clk),
        .rst_i        (rst_i),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_tag_i    (req_tag_i),
        .cfg_valid_i  (cfg_valid_i),
        .cfg_type_i   (cfg_type_i),
        .chan_req_o   (chan_req),
        .chan_write_o (chan_write),
        .chan_addr_o  (chan_addr),
        .chan_wdata_o (chan_wdata),
        .chan_tag_o   (chan_tag),
        .chan_type_o  (chan_type)
    );

    ////////////////////////////////////////////////////////////////////////////
    // One access engine per TURFIO link
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < LINK_COUNT; g++) begin : g_link
        crate_link_channel u_chan (
            .ps_clk       (ps_clk),
            .rst_i        (rst_i),
            .req_i        (chan_req[g]),
            .write_i      (chan_write),
            .addr_i       (chan_addr),
            .wdata_i      (chan_wdata),
            .tag_i        (chan_tag),
            .type_i       (chan_type[g]),
            .link_up_i    (link_up_i[g]),
            .cmd_valid_o  (link_cmd_valid_o[g]),
            .cmd_write_o  (link_cmd_write_o[g]),
            .cmd_addr_o   (link_cmd_addr_o[g]),
            .cmd_wdata_o  (link_cmd_wdata_o[g]),
            .resp_valid_i (link_resp_valid_i[g]),
            .resp_data_i  (link_resp_data_i[g]),
            .done_o       (chan_done[g]),
            .status_o     (chan_status[g]),
            .rdata_o      (chan_rdata[g]),
            .tag_o        (chan_tag_out[g]),
            .take_i       (chan_take[g])
        );
    end

    crate_response_merge u_merge (
        .ps_clk         (ps_clk),
        .rst_i          (rst_i),
        .clear_flags_i  (clear_flags_i),
        .done_i         (chan_done),
        .status_i       (chan_status),
        .rdata_i        (chan_rdata),
        .tag_i          (chan_tag_out),
        .take_o         (chan_take),
        .resp_valid_o   (resp_valid_o),
        .resp_status_o  (resp_status_o),
        .resp_rdata_o   (resp_rdata_o),
        .resp_tag_o     (resp_tag_o),
        .resp_link_o    (resp_link_o),
        .timeout_flag_o (timeout_flag_o),
        .invalid_flag_o (invalid_flag_o)
    );

endmodule

/* tb_crate_remote.sv */
`timescale 1ns/1ns

module tb_crate_remote import crate_bridge_pkg::*; (
    input  logic                                   ps_clk,
    input  logic                                   rst_i,
    input  logic [LINK_COUNT-1:0]                  cmd_valid_i,
    input  logic [LINK_COUNT-1:0]                  cmd_write_i,
    input  logic [LINK_COUNT-1:0][LINK_ADDR_W-1:0] cmd_addr_i,
    input  logic [LINK_COUNT-1:0][DATA_W-1:0]      cmd_wdata_i,
    input  logic [LINK_COUNT-1:0]                  drop_i,
    output logic [LINK_COUNT-1:0]                  resp_valid_o,
    output logic [LINK_COUNT-1:0][DATA_W-1:0]      resp_data_o
);

    // Remote register space, keyed by link and link address
    logic [DATA_W-1:0]     mem [logic [ADDR_W-1:0]];
    logic [LINK_COUNT-1:0] pend_q;
    int                    wait_q [LINK_COUNT];
    logic [DATA_W-1:0]     data_q [LINK_COUNT];
    logic [ADDR_W-1:0]     key;
    integer                seed = 32'h2d1b2f7b;

    always @(posedge ps_clk) begin
        for (int l = 0; l < LINK_COUNT; l++) begin
            resp_valid_o[l] <= 1'b0;
            if (rst_i) begin
                pend_q[l] = 1'b0;
            end else if (cmd_valid_i[l] && !drop_i[l]) begin
                key = {LINK_SEL_W'(l), cmd_addr_i[l]};
                if (cmd_write_i[l]) begin
                    mem[key] = cmd_wdata_i[l];
                    // Junk on the write ack, the bridge must drop it
                    data_q[l] = ~cmd_wdata_i[l];
                end else begin
                    data_q[l] = mem.exists(key) ? mem[key] : '0;
                end
                wait_q[l] = 1 + ($unsigned($random(seed)) % 40);
                pend_q[l] = 1'b1;
            end
            // Answer lands wait_q cycles after the command edge
            if (pend_q[l]) begin
                wait_q[l] = wait_q[l] - 1;
                if (wait_q[l] == 0) begin
                    pend_q[l] = 1'b0;
                    resp_valid_o[l] <= 1'b1;
                    resp_data_o[l]  <= data_q[l];
                end
            end
        end
    end

endmodule

/* tb_crate_bridge.sv */
`timescale 1ns/1ns

module tb_crate_bridge import crate_bridge_pkg::*; ();

    localparam int CLK_HALF  = 4;
    localparam int N_RAND    = 20;
    localparam int N_FWD     = 60;
    localparam int N_INVALID = 12;
    localparam int N_DROP    = LINK_COUNT;
    localparam int N_BURST   = 4 * LINK_COUNT;
    localparam int N_TOTAL   = N_RAND + N_FWD + N_INVALID + N_DROP + N_BURST;

    logic                                   ps_clk;
    logic                                   rst_i;
    logic                                   req_valid_i;
    logic                                   req_write_i;
    logic [ADDR_W-1:0]                      req_addr_i;
    logic [DATA_W-1:0]                      req_wdata_i;
    logic [TAG_W-1:0]                       req_tag_i;
    logic                                   cfg_valid_i;
    logic [BRIDGE_CFG_W-1:0]                cfg_type_i;
    logic                                   clear_flags_i;
    logic [LINK_COUNT-1:0]                  link_up_i;
    logic [LINK_COUNT-1:0]                  link_cmd_valid_o;
    logic [LINK_COUNT-1:0]                  link_cmd_write_o;
    logic [LINK_COUNT-1:0][LINK_ADDR_W-1:0] link_cmd_addr_o;
    logic [LINK_COUNT-1:0][DATA_W-1:0]      link_cmd_wdata_o;
    logic [LINK_COUNT-1:0]                  link_resp_valid_i;
    logic [LINK_COUNT-1:0][DATA_W-1:0]      link_resp_data_i;
    logic                                   resp_valid_o;
    resp_status_e                           resp_status_o;
    logic [DATA_W-1:0]                      resp_rdata_o;
    logic [TAG_W-1:0]                       resp_tag_o;
    logic [LINK_SEL_W-1:0]                  resp_link_o;
    logic [LINK_COUNT-1:0]                  timeout_flag_o;
    logic [LINK_COUNT-1:0]                  invalid_flag_o;
    logic [LINK_COUNT-1:0]                  drop_q;

    // Reference model state per link
    bridge_type_e           m_type [LINK_COUNT];
    logic [LINK_COUNT-1:0]  busy;
    logic [LINK_COUNT-1:0]  solo;
    logic [LINK_COUNT-1:0]  exp_cmd;
    logic [LINK_COUNT-1:0]  cmd_seen;
    logic [LINK_COUNT-1:0]  exp_write;
    logic [LINK_COUNT-1:0]  m_timeout;
    logic [LINK_COUNT-1:0]  m_invalid;
    resp_status_e           exp_status [LINK_COUNT];
    logic [DATA_W-1:0]      exp_data [LINK_COUNT];
    logic [TAG_W-1:0]       exp_tag [LINK_COUNT];
    logic [LINK_ADDR_W-1:0] exp_addr [LINK_COUNT];
    logic [DATA_W-1:0]      exp_wdata [LINK_COUNT];
    time                    req_time [LINK_COUNT];
    time                    cmd_time [LINK_COUNT];
    logic [DATA_W-1:0]      mirror [logic [ADDR_W-1:0]];
    integer                 seed = 32'h2d1b2f7b;
    int                     n_checks;
    int                     n_errors;
    int                     n_tests;
    int                     n_bad_tests;
    int                     err_mark;

    always #CLK_HALF ps_clk = ~ps_clk;

    crate_bridge_top dut0 (.*);

    tb_crate_remote u_remote (
        .ps_clk       (ps_clk),
        .rst_i        (rst_i),
        .cmd_valid_i  (link_cmd_valid_o),
        .cmd_write_i  (link_cmd_write_o),
        .cmd_addr_i   (link_cmd_addr_o),
        .cmd_wdata_i  (link_cmd_wdata_o),
        .drop_i       (drop_q),
        .resp_valid_o (link_resp_valid_i),
        .resp_data_o  (link_resp_data_i)
    );

    task automatic compare(input bit ok, input string what);
        n_checks++;
        assert (ok) else begin
            n_errors++;
            $display("MISMATCH at %0t ns: %s", $time, what);
        end
    endtask

    task automatic require(input bit ok, input string what);
        n_checks++;
        assert (ok) else begin
            n_errors++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic next_cycle;
        @(posedge ps_clk);
        req_valid_i   <= 1'b0;
        cfg_valid_i   <= 1'b0;
        clear_flags_i <= 1'b0;
    endtask

    task automatic configure(input logic [BRIDGE_CFG_W-1:0] cfg,
                             input logic [LINK_COUNT-1:0] up);
        @(posedge ps_clk);
        cfg_valid_i <= 1'b1;
        cfg_type_i  <= cfg;
        link_up_i   <= up;
        for (int l = 0; l < LINK_COUNT; l++) begin
            m_type[l] = bridge_type_e'(cfg[2*l +: 2]);
        end
        next_cycle();
    endtask

    // Drives one request and records what the bridge should return
    task automatic send_access(input int link, input bit write);
        logic [LINK_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      wdata;
        logic [TAG_W-1:0]       tag;
        logic [ADDR_W-1:0]      key;
        addr = LINK_ADDR_W'($random(seed));
        // Small window half of the time so reads hit earlier writes
        if ($random(seed) & 1) begin
            addr = addr & 25'h7;
        end
        wdata = $random(seed);
        tag   = $random(seed);
        key   = {LINK_SEL_W'(link), addr};
        @(posedge ps_clk);
        req_valid_i <= 1'b1;
        req_write_i <= write;
        req_addr_i  <= key;
        req_wdata_i <= wdata;
        req_tag_i   <= tag;
        solo[link]      = (busy == '0);
        busy[link]      = 1'b1;
        cmd_seen[link]  = 1'b0;
        req_time[link]  = $time + 2 * CLK_HALF;
        exp_tag[link]   = tag;
        exp_write[link] = write;
        exp_addr[link]  = addr;
        exp_wdata[link] = wdata;
        exp_data[link]  = '0;
        exp_cmd[link]   = (m_type[link] == BRIDGE_AURORA) && link_up_i[link];
        if (m_type[link] == BRIDGE_NONE) begin
            exp_status[link] = STATUS_NO_BRIDGE;
        end else if (!exp_cmd[link]) begin
            exp_status[link] = STATUS_INVALID;
        end else if (drop_q[link]) begin
            exp_status[link] = STATUS_TIMEOUT;
        end else begin
            exp_status[link] = STATUS_OK;
            if (write) begin
                mirror[key] = wdata;
            end else if (mirror.exists(key)) begin
                exp_data[link] = mirror[key];
            end
        end
    endtask

    task automatic wait_idle;
        int cycles;
        cycles = 0;
        while (busy != '0 && cycles < TIMEOUT_CYCLES + 100) begin
            @(posedge ps_clk);
            cycles++;
        end
        require(busy == '0, "an access never completed");
    endtask

    task automatic clear_sticky;
        @(posedge ps_clk);
        clear_flags_i <= 1'b1;
        next_cycle();
        m_timeout = '0;
        m_invalid = '0;
        @(negedge ps_clk);
        compare(timeout_flag_o == m_timeout && invalid_flag_o == m_invalid,
                "flags not cleared");
    endtask

    task automatic check_completion(input int link);
        require(busy[link], $sformatf("completion from idle link %0d", link));
        compare(resp_tag_o == exp_tag[link], $sformatf("link %0d tag %0h, expected %0h",
                link, resp_tag_o, exp_tag[link]));
        compare(resp_status_o == exp_status[link], $sformatf("link %0d status %s, expected %s",
                link, resp_status_o.name(), exp_status[link].name()));
        compare(resp_rdata_o == exp_data[link], $sformatf("link %0d data %0h, expected %0h",
                link, resp_rdata_o, exp_data[link]));
        require(cmd_seen[link] == exp_cmd[link],
                $sformatf("link %0d completed without its command", link));
        if (exp_status[link] == STATUS_TIMEOUT) begin
            require($time - cmd_time[link] >= TIMEOUT_CYCLES * 2 * CLK_HALF,
                    $sformatf("link %0d timed out too early", link));
            m_timeout[link] = 1'b1;
        end
        if (exp_status[link] == STATUS_INVALID) begin
            m_invalid[link] = 1'b1;
        end
        // Uncontended immediate outcome is three cycles from the request edge
        if (solo[link] && !exp_cmd[link] && busy == (LINK_COUNT'(1) << link)) begin
            compare($time - req_time[link] == 3 * 2 * CLK_HALF - CLK_HALF,
                    $sformatf("link %0d immediate latency", link));
        end
        compare(timeout_flag_o == m_timeout, "timeout flags");
        compare(invalid_flag_o == m_invalid, "invalid flags");
        busy[link] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Link and completion monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge ps_clk) begin
        if (!rst_i) begin
            for (int l = 0; l < LINK_COUNT; l++) begin
                if (link_cmd_valid_o[l]) begin
                    require(busy[l] && exp_cmd[l] && !cmd_seen[l],
                            $sformatf("unexpected command on link %0d", l));
                    compare(link_cmd_write_o[l] == exp_write[l] &&
                            link_cmd_addr_o[l] == exp_addr[l] &&
                            link_cmd_wdata_o[l] == exp_wdata[l],
                            $sformatf("command fields on link %0d", l));
                    cmd_seen[l] = 1'b1;
                    cmd_time[l] = $time;
                end
            end
            if (resp_valid_o) begin
                check_completion(resp_link_o);
            end
        end
    end

    task automatic report_test(input string name);
        n_tests++;
        if (n_errors == err_mark) begin
            $display("test %0d %s: passed", n_tests, name);
        end else begin
            n_bad_tests++;
            $display("test %0d %s: failed, %0d errors", n_tests, name, n_errors - err_mark);
        end
        err_mark = n_errors;
    endtask

    initial begin
        repeat (16 + N_TOTAL * (TIMEOUT_CYCLES + 50)) @(posedge ps_clk);
        $display("Watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        int link;
        int sent;
        ps_clk        = 1'b0;
        rst_i         = 1'b1;
        req_valid_i   = 1'b0;
        req_write_i   = 1'b0;
        req_addr_i    = '0;
        req_wdata_i   = '0;
        req_tag_i     = '0;
        cfg_valid_i   = 1'b0;
        cfg_type_i    = '0;
        clear_flags_i = 1'b0;
        link_up_i     = '1;
        drop_q        = '0;
        busy          = '0;
        exp_cmd       = '0;
        m_timeout     = '0;
        m_invalid     = '0;
        for (int l = 0; l < LINK_COUNT; l++) begin
            m_type[l] = BRIDGE_NONE;
        end
        repeat (16) @(posedge ps_clk);
        rst_i <= 1'b0;
        @(negedge ps_clk);
        compare(!resp_valid_o && link_cmd_valid_o == '0 && timeout_flag_o == '0 &&
                invalid_flag_o == '0, "outputs after reset");

        for (int i = 0; i < N_RAND; i++) begin
            send_access($unsigned($random(seed)) % LINK_COUNT, $random(seed) & 1);
            next_cycle();
            wait_idle();
        end
        report_test("default no-bridge");

        configure({LINK_COUNT{BRIDGE_AURORA}}, '1);
        sent = 0;
        while (sent < N_FWD) begin
            link = $unsigned($random(seed)) % LINK_COUNT;
            if (!busy[link]) begin
                send_access(link, $random(seed) & 1);
                sent++;
            end
            next_cycle();
        end
        wait_idle();
        report_test("forwarded reads and writes");

        // Link 0 down, links 2 and 3 on reserved types
        configure({BRIDGE_RSVD3, BRIDGE_RSVD2, BRIDGE_AURORA, BRIDGE_AURORA}, 4'b1110);
        for (int i = 0; i < N_INVALID; i++) begin
            send_access(i % LINK_COUNT, $random(seed) & 1);
            next_cycle();
            wait_idle();
        end
        clear_sticky();
        report_test("invalid accesses");

        configure({LINK_COUNT{BRIDGE_AURORA}}, '1);
        for (int l = 0; l < N_DROP; l++) begin
            @(posedge ps_clk);
            drop_q <= LINK_COUNT'(1) << l;
            send_access(l, 1'b0);
            next_cycle();
            wait_idle();
        end
        @(posedge ps_clk);
        drop_q <= '0;
        clear_sticky();
        report_test("response timeout");

        for (int r = 0; r < N_BURST / LINK_COUNT; r++) begin
            if (r == N_BURST / LINK_COUNT - 1) begin
                configure({BRIDGE_NONE, BRIDGE_RSVD2, BRIDGE_AURORA, BRIDGE_AURORA},
                          4'b1101);
            end
            for (int k = 0; k < LINK_COUNT; k++) begin
                send_access((k + r) % LINK_COUNT, $random(seed) & 1);
            end
            next_cycle();
            wait_idle();
        end
        report_test("back-to-back bursts");

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 n_tests, n_bad_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
crate_bridge_pkg.sv
crate_access_dispatch.sv
crate_link_channel.sv
crate_response_merge.sv
crate_bridge_top.sv
tb_crate_remote.sv
tb_crate_bridge.sv
